/* Makefile */
TOP = tof_hist_tb
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Testbench failed" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Testbench passed" $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

/* rtl/bin_quantizer.sv */
`timescale 1ns/1ps

module bin_quantizer (
    input  logic                          clk,
    input  logic                          combin_res,
    input  logic                          ts_valid,
    input  logic [tof_hist_pkg::TS_W-1:0] timestamp,
    output logic                          bin_valid,
    output logic [tof_hist_pkg::NB-1:0]   bin_addr
);

    logic [tof_hist_pkg::TS_W-1:0] ts_rel;
    logic                          below_win;
    logic                          beyond_win;
    logic [tof_hist_pkg::NB-1:0]   bin_next;

    always_comb begin
        // offset into the window, wraps when below it
        ts_rel = timestamp - tof_hist_pkg::TS_OFFSET;
        below_win = timestamp < tof_hist_pkg::TS_OFFSET;
        // any bit above the bin field means past the last bin
        beyond_win = |ts_rel[tof_hist_pkg::TS_W-1:tof_hist_pkg::BIN_SHIFT+tof_hist_pkg::NB];
        if (below_win) begin
            bin_next = '0;
        end else if (beyond_win) begin
            bin_next = tof_hist_pkg::BIN_LAST;
        end else begin
            // drop the fine bits
            bin_next = ts_rel[tof_hist_pkg::BIN_SHIFT +: tof_hist_pkg::NB];
        end
    end

    // strobe, one cycle behind ts_valid
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            bin_valid <= 1'b0;
        end else begin
            bin_valid <= ts_valid;
        end
    end

    // bin address, only loaded on an event
    always_ff @(posedge clk) begin
        if (ts_valid) begin
            bin_addr <= bin_next;
        end
    end

endmodule

/* rtl/histogram_builder.sv */
`timescale 1ns/1ps

module histogram_builder (
    input  logic                           clk,
    input  logic                           combin_res,
    input  logic                           bin_valid,
    input  logic [tof_hist_pkg::NB-1:0]    bin_addr,
    input  logic [tof_hist_pkg::RD_W-1:0]  rd_addr,
    output logic [tof_hist_pkg::CNT_W-1:0] rd_count,
    output logic                           his_num,
    output logic                           frame_done
);

    // two banks of counts, bank index is his_num
    logic [tof_hist_pkg::CNT_W-1:0] mem_bank [2][tof_hist_pkg::BIN_NUM_PER_RAM];
    // per-bin valid bits, cleared in one cycle on a swap
    logic [tof_hist_pkg::BIN_NUM_PER_RAM-1:0] bin_vld [2];

    // frame position
    logic [tof_hist_pkg::EVT_W-1:0] evt_cnt;
    logic [tof_hist_pkg::PIX_W-1:0] pix_cnt;
    logic [tof_hist_pkg::ACQ_W-1:0] acq_cnt;

    logic                           rd_bank;
    logic [tof_hist_pkg::RD_W-1:0]  wr_addr;
    logic                           wr_hit;
    logic [tof_hist_pkg::CNT_W-1:0] wr_data;
    logic                           evt_last;
    logic                           pix_last;
    logic                           acq_last;
    logic                           frame_last;

    always_comb begin
        // finished bank is the one not being written
        rd_bank = ~his_num;
        // pixel * 16 + bin, bins per pixel is a power of two
        wr_addr = {pix_cnt, bin_addr};
        wr_hit = bin_vld[his_num][wr_addr];
        // first hit of a bin restarts at 1, old contents are stale
        wr_data = wr_hit ? mem_bank[his_num][wr_addr] + 1'b1 : tof_hist_pkg::CNT_W'(1);
        evt_last = evt_cnt == tof_hist_pkg::EVT_LAST;
        pix_last = pix_cnt == tof_hist_pkg::PIX_LAST;
        acq_last = acq_cnt == tof_hist_pkg::ACQ_LAST;
        frame_last = evt_last && pix_last && acq_last;
    end

    // read port for the peak finder
    always_comb begin
        if (bin_vld[rd_bank][rd_addr]) begin
            rd_count = mem_bank[rd_bank][rd_addr];
        end else begin
            // never written this frame
            rd_count = '0;
        end
    end

    // count storage
    always_ff @(posedge clk) begin
        if (bin_valid) begin
            mem_bank[his_num][wr_addr] <= wr_data;
        end
    end

    // valid bits, counters and bank swap
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            bin_vld[0] <= '0;
            bin_vld[1] <= '0;
            evt_cnt <= '0;
            pix_cnt <= '0;
            acq_cnt <= '0;
            his_num <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            if (bin_valid) begin
                bin_vld[his_num][wr_addr] <= 1'b1;
                // events, then pixels, then acquisitions
                if (!evt_last) begin
                    evt_cnt <= evt_cnt + 1'b1;
                end else begin
                    evt_cnt <= '0;
                    if (!pix_last) begin
                        pix_cnt <= pix_cnt + 1'b1;
                    end else begin
                        pix_cnt <= '0;
                        if (!acq_last) begin
                            acq_cnt <= acq_cnt + 1'b1;
                        end else begin
                            acq_cnt <= '0;
                        end
                    end
                end
                if (frame_last) begin
                    // swap banks, the new active bank starts empty
                    his_num <= ~his_num;
                    bin_vld[rd_bank] <= '0;
                    frame_done <= 1'b1;
                end
            end
        end
    end

endmodule

/* rtl/peak_finder.sv */
`timescale 1ns/1ps

module peak_finder (
    input  logic                           clk,
    input  logic                           combin_res,
    input  logic                           frame_done,
    input  logic [tof_hist_pkg::CNT_W-1:0] rd_count,
    output logic [tof_hist_pkg::RD_W-1:0]  rd_addr,
    output logic                           peak_valid,
    output logic [tof_hist_pkg::PIX_W-1:0] peak_pixel,
    output logic [tof_hist_pkg::NB-1:0]    peak_bin,
    output logic [tof_hist_pkg::CNT_W-1:0] peak_count,
    output logic                           busy,
    output logic                           overrun
);

    tof_hist_pkg::peak_state_e state;

    // pixel and bin being read this cycle
    logic [tof_hist_pkg::RD_W-1:0]  scan_addr;
    logic [tof_hist_pkg::NB-1:0]    cur_bin;
    // running maximum of the current pixel
    logic [tof_hist_pkg::CNT_W-1:0] best_count;
    logic [tof_hist_pkg::NB-1:0]    best_bin;
    logic                           take;
    logic [tof_hist_pkg::CNT_W-1:0] next_count;
    logic [tof_hist_pkg::NB-1:0]    next_bin;

    always_comb begin
        cur_bin = scan_addr[tof_hist_pkg::NB-1:0];
        // bin 0 restarts the max, strict compare keeps the lowest bin on a tie
        take = (cur_bin == '0) || (rd_count > best_count);
        next_count = take ? rd_count : best_count;
        next_bin = take ? cur_bin : best_bin;
    end

    assign rd_addr = scan_addr;
    assign busy = state != tof_hist_pkg::PK_IDLE;

    always_ff @(posedge clk) begin
        if (state != tof_hist_pkg::PK_IDLE) begin
            best_count <= next_count;
            best_bin <= next_bin;
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            state <= tof_hist_pkg::PK_IDLE;
            scan_addr <= '0;
            peak_valid <= 1'b0;
            peak_pixel <= '0;
            peak_bin <= '0;
            peak_count <= '0;
            overrun <= 1'b0;
        end else begin
            peak_valid <= 1'b0;
            // new frame while still scanning, sticky until reset
            if (frame_done && state != tof_hist_pkg::PK_IDLE) begin
                overrun <= 1'b1;
            end
            case (state)
                tof_hist_pkg::PK_IDLE: begin
                    if (frame_done) begin
                        state <= tof_hist_pkg::PK_SCAN;
                    end
                end
                default: begin
                    // address wrapped to 0 in emit means all pixels are done
                    if (state == tof_hist_pkg::PK_EMIT && scan_addr == '0) begin
                        state <= tof_hist_pkg::PK_IDLE;
                    end else begin
                        scan_addr <= scan_addr + 1'b1;
                        if (cur_bin == tof_hist_pkg::BIN_LAST) begin
                            // last bin folded into the result
                            peak_valid <= 1'b1;
                            peak_pixel <= scan_addr[tof_hist_pkg::RD_W-1:tof_hist_pkg::NB];
                            peak_bin <= next_bin;
                            peak_count <= next_count;
                            state <= tof_hist_pkg::PK_EMIT;
                        end else begin
                            state <= tof_hist_pkg::PK_SCAN;
                        end
                    end
                end
            endcase
        end
    end

endmodule

/* rtl/tof_hist_pkg.sv */
package tof_hist_pkg;

    // raw timestamp from the tdc
    localparam int TS_W = 8;

    // bin address and bins per pixel histogram
    localparam int NB = 4;
    localparam int BIN_NUM_PER_HIS = 16;

    // timing window, start code and codes per bin (2**BIN_SHIFT)
    localparam logic [TS_W-1:0] TS_OFFSET = TS_W'(32);
    localparam int BIN_SHIFT = 3;

    // frame structure: events, pixels, acquisitions
    localparam int DATA_NUM = 2;
    localparam int PIXEL_NUM = 4;
    localparam int PIX_W = 2;
    localparam int ACQ_NUM = 3;

    // counter widths for the builder
    localparam int EVT_W = 1;
    localparam int ACQ_W = 2;

    // count width covers ACQ_NUM * DATA_NUM = 6, no saturation needed
    localparam int CNT_W = 3;

    // one bank holds every pixel
    localparam int BIN_NUM_PER_RAM = PIXEL_NUM * BIN_NUM_PER_HIS;
    localparam int RD_W = PIX_W + NB;

    // terminal counts
    localparam logic [EVT_W-1:0] EVT_LAST = EVT_W'(DATA_NUM - 1);
    localparam logic [PIX_W-1:0] PIX_LAST = PIX_W'(PIXEL_NUM - 1);
    localparam logic [ACQ_W-1:0] ACQ_LAST = ACQ_W'(ACQ_NUM - 1);
    localparam logic [NB-1:0] BIN_LAST = NB'(BIN_NUM_PER_HIS - 1);

    // peak scanner
    typedef enum logic [1:0] {PK_IDLE, PK_SCAN, PK_EMIT} peak_state_e;

endpackage

/* rtl/tof_hist_top.sv */
`timescale 1ns/1ps

module tof_hist_top (
    input  logic                           clk,
    input  logic                           combin_res,
    input  logic                           ts_valid,
    input  logic [tof_hist_pkg::TS_W-1:0]  timestamp,
    output logic                           his_num,
    output logic                           frame_done,
    output logic                           peak_valid,
    output logic [tof_hist_pkg::PIX_W-1:0] peak_pixel,
    output logic [tof_hist_pkg::NB-1:0]    peak_bin,
    output logic [tof_hist_pkg::CNT_W-1:0] peak_count,
    output logic                           busy,
    output logic                           overrun
);

    // quantizer to builder
    logic                           bin_valid;
    logic [tof_hist_pkg::NB-1:0]    bin_addr;
    // peak finder read port into the finished bank
    logic [tof_hist_pkg::RD_W-1:0]  rd_addr;
    logic [tof_hist_pkg::CNT_W-1:0] rd_count;

    bin_quantizer u_quant (
        .clk        (clk),
        .combin_res (combin_res),
        .ts_valid   (ts_valid),
        .timestamp  (timestamp),
        .bin_valid  (bin_valid),
        .bin_addr   (bin_addr)
    );

    histogram_builder u_builder (
        .clk        (clk),
        .combin_res (combin_res),
        .bin_valid  (bin_valid),
        .bin_addr   (bin_addr),
        .rd_addr    (rd_addr),
        .rd_count   (rd_count),
        .his_num    (his_num),
        .frame_done (frame_done)
    );

    peak_finder u_peak (
        .clk        (clk),
        .combin_res (combin_res),
        .frame_done (frame_done),
        .rd_count   (rd_count),
        .rd_addr    (rd_addr),
        .peak_valid (peak_valid),
        .peak_pixel (peak_pixel),
        .peak_bin   (peak_bin),
        .peak_count (peak_count),
        .busy       (busy),
        .overrun    (overrun)
    );

endmodule

/* tests/tof_hist_sva.sv */
`timescale 1ns/1ps

module tof_hist_sva (
    input logic                           clk,
    input logic                           combin_res,
    input logic                           his_num,
    input logic                           frame_done,
    input logic                           peak_valid,
    input logic [tof_hist_pkg::CNT_W-1:0] peak_count,
    input logic                           busy,
    input logic                           overrun,
    input tof_hist_pkg::peak_state_e      pk_state
);

    // set by the first frame after reset
    logic frame_seen;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            frame_seen <= 1'b0;
        end else if (frame_done) begin
            frame_seen <= 1'b1;
        end
    end

    // single-cycle pulse
    frame_done_pulse: assert property (@(posedge clk) disable iff (!combin_res)
        frame_done |=> !frame_done)
        else $error("frame_done high for more than one cycle");

    // bank swap and frame_done go together
    frame_done_swap: assert property (@(posedge clk) disable iff (!combin_res)
        (his_num != $past(his_num)) == frame_done)
        else $error("his_num toggle and frame_done out of step");

    peak_in_emit: assert property (@(posedge clk) disable iff (!combin_res)
        peak_valid |-> pk_state == tof_hist_pkg::PK_EMIT)
        else $error("peak_valid outside the emit state");

    // ACQ_NUM * DATA_NUM events per pixel at most
    peak_count_max: assert property (@(posedge clk) disable iff (!combin_res)
        int'(peak_count) <= tof_hist_pkg::ACQ_NUM * tof_hist_pkg::DATA_NUM)
        else $error("peak_count above the events per pixel");

    quiet_before_frame: assert property (@(posedge clk) disable iff (!combin_res)
        !frame_seen |-> !busy && !overrun)
        else $error("busy or overrun set before the first frame");

endmodule

/* tests/tof_hist_tb.sv */
`timescale 1ns/1ps

module tof_hist_tb;

    logic                           clk;
    logic                           combin_res;
    logic                           ts_valid;
    logic [tof_hist_pkg::TS_W-1:0]  timestamp;
    logic                           his_num;
    logic                           frame_done;
    logic                           peak_valid;
    logic [tof_hist_pkg::PIX_W-1:0] peak_pixel;
    logic [tof_hist_pkg::NB-1:0]    peak_bin;
    logic [tof_hist_pkg::CNT_W-1:0] peak_count;
    logic                           busy;
    logic                           overrun;

    // one frame in send order, and the model's peak per pixel
    int frame_ts[$];
    int exp_bin[tof_hist_pkg::PIXEL_NUM];
    int exp_cnt[tof_hist_pkg::PIXEL_NUM];
    int test_errs;
    int tests_run;
    int tests_failed;

    tof_hist_top uut (.*);

    bind tof_hist_top tof_hist_sva u_sva (
        .clk(clk), .combin_res(combin_res), .his_num(his_num), .frame_done(frame_done),
        .peak_valid(peak_valid), .peak_count(peak_count), .busy(busy), .overrun(overrun),
        .pk_state(u_peak.state)
    );

    always #2 clk = ~clk;

    // window starts at 32, 8 codes per bin, clamped at both ends
    function automatic int model_bin(int ts);
        int rel;
        if (ts < 32) begin
            return 0;
        end
        rel = (ts - 32) / 8;
        return (rel < 16) ? rel : 15;
    endfunction

    // events fill a pixel, then the next pixel, then the next acquisition
    function automatic void build_model();
        int hist[tof_hist_pkg::PIXEL_NUM][tof_hist_pkg::BIN_NUM_PER_HIS];
        int pix;
        foreach (hist[p, b]) begin
            hist[p][b] = 0;
        end
        foreach (frame_ts[i]) begin
            pix = (i / tof_hist_pkg::DATA_NUM) % tof_hist_pkg::PIXEL_NUM;
            hist[pix][model_bin(frame_ts[i])]++;
        end
        for (int p = 0; p < tof_hist_pkg::PIXEL_NUM; p++) begin
            exp_bin[p] = 0;
            exp_cnt[p] = hist[p][0];
            // only a larger count moves the peak, ties keep the lower bin
            for (int b = 1; b < tof_hist_pkg::BIN_NUM_PER_HIS; b++) begin
                if (hist[p][b] > exp_cnt[p]) begin
                    exp_bin[p] = b;
                    exp_cnt[p] = hist[p][b];
                end
            end
        end
    endfunction

    // mode 0 in-window, 1 outside the window, 2 two tied bins per pixel
    function automatic void fill_frame(int mode);
        int edges[4] = '{0, 31, 160, 255};
        int pix;
        int acq;
        int bin;
        int ts;
        frame_ts.delete();
        for (int i = 0; i < 24; i++) begin
            pix = (i / 2) % 4;
            acq = i / 8;
            if (mode == 0) begin
                ts = 32 + int'($urandom_range(127, 0));
            end else if (mode == 1) begin
                // exact window edges first
                if (i < 4) begin
                    ts = edges[i];
                end else if ($urandom_range(1, 0) != 0) begin
                    ts = int'($urandom_range(31, 0));
                end else begin
                    ts = int'($urandom_range(255, 160));
                end
            end else begin
                // high bin hit first, both end up with 3
                bin = (acq == 1 || (acq == 2 && i % 2 == 0)) ? 2 + pix : 9 + pix;
                ts = 32 + 8 * bin + int'($urandom_range(7, 0));
            end
            frame_ts.push_back(ts);
        end
    endfunction

    task automatic check_value(string name, string what, int expected, int actual);
        assert (actual == expected) else begin
            $display("mismatch %s %s: expected %0d, actual %0d", name, what, expected, actual);
            test_errs++;
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        combin_res = 1'b0;
        ts_valid = 1'b0;
        repeat (2) @(negedge clk);
        combin_res = 1'b1;
    endtask

    task automatic check_idle(string name);
        check_value(name, "his_num", 0, int'(his_num));
        check_value(name, "busy", 0, int'(busy));
        check_value(name, "overrun", 0, int'(overrun));
        check_value(name, "frame_done", 0, int'(frame_done));
        check_value(name, "peak_valid", 0, int'(peak_valid));
    endtask

    // one event per cycle, ts_valid stays high after the last
    task automatic send_frame();
        logic [31:0] word;
        foreach (frame_ts[i]) begin
            @(negedge clk);
            word = frame_ts[i];
            ts_valid = 1'b1;
            timestamp = word[tof_hist_pkg::TS_W-1:0];
        end
    endtask

    task automatic collect_peaks(string name, bit check_lat);
        int cycles;
        logic his_before;
        logic seen_done;
        his_before = his_num;
        seen_done = 1'b0;
        cycles = 0;
        do begin
            @(negedge clk);
            ts_valid = 1'b0;
            seen_done |= frame_done;
            cycles++;
        end while (!peak_valid && cycles < 100);
        assert (seen_done) else begin
            $display("test %s: frame_done did not pulse after the last event", name);
            test_errs++;
        end
        check_value(name, "his_num", int'(!his_before), int'(his_num));
        if (check_lat) begin
            check_value(name, "latency", 19, cycles);
        end
        for (int p = 0; p < tof_hist_pkg::PIXEL_NUM; p++) begin
            cycles = 0;
            while (p > 0 && cycles == 0 || !peak_valid && cycles < 40) begin
                @(negedge clk);
                cycles++;
            end
            if (!peak_valid) begin
                $display("test %s: timeout waiting for the result of pixel %0d", name, p);
                test_errs++;
                return;
            end
            check_value(name, "peak_pixel", p, int'(peak_pixel));
            check_value(name, "peak_bin", exp_bin[p], int'(peak_bin));
            check_value(name, "peak_count", exp_cnt[p], int'(peak_count));
            // scan still running while each result goes out
            check_value(name, "busy", 1, int'(busy));
        end
    endtask

    task automatic wait_idle(string name);
        int cycles;
        cycles = 0;
        while (busy && cycles < 200) begin
            @(negedge clk);
            cycles++;
        end
        if (busy) begin
            $display("test %s: timeout waiting for the scan to end", name);
            test_errs++;
        end
    endtask

    task automatic run_frame(string name, int mode, bit check_lat);
        fill_frame(mode);
        build_model();
        send_frame();
        collect_peaks(name, check_lat);
        wait_idle(name);
    endtask

    task automatic finish_test(string name);
        tests_run++;
        if (test_errs == 0) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, test_errs);
        end
        test_errs = 0;
    endtask

    initial begin
        void'($urandom(92));
        clk = 1'b0;
        combin_res = 1'b0;
        ts_valid = 1'b0;
        timestamp = '0;
        test_errs = 0;
        tests_run = 0;
        tests_failed = 0;
        apply_reset();
        check_idle("reset");
        finish_test("reset");
        run_frame("random_frame", 0, 1'b1);
        finish_test("random_frame");
        run_frame("window_edges", 1, 1'b0);
        finish_test("window_edges");
        run_frame("tie_low_bin", 2, 1'b0);
        finish_test("tie_low_bin");
        // each bank written again with new data
        run_frame("ping_pong", 0, 1'b0);
        run_frame("ping_pong", 0, 1'b0);
        finish_test("ping_pong");
        // frames back to back, the later two end during the first scan
        check_value("overrun", "overrun before", 0, int'(overrun));
        repeat (3) begin
            fill_frame(0);
            send_frame();
        end
        @(negedge clk);
        ts_valid = 1'b0;
        check_value("overrun", "overrun", 1, int'(overrun));
        wait_idle("overrun");
        repeat (10) @(negedge clk);
        check_value("overrun", "overrun after scan", 1, int'(overrun));
        apply_reset();
        check_idle("overrun");
        finish_test("overrun");
        $display("%0d tests run, %0d failed", tests_run, tests_failed);
        if (tests_failed == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* verilog.f */
rtl/tof_hist_pkg.sv
rtl/bin_quantizer.sv
rtl/histogram_builder.sv
rtl/peak_finder.sv
rtl/tof_hist_top.sv
tests/tof_hist_sva.sv
tests/tof_hist_tb.sv
